// ==== verilog/mem_ctrl_pkg.sv ====
// shared widths, enums and bus structs for the dual-core memory controller, imported by every module
package mem_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // widths and depths

    localparam int WORD_W        = 32;
    localparam int BLOCK_ADDR_W  = 13;
    localparam int READ_Q_DEPTH  = 4;
    localparam int WRITE_Q_DEPTH = 8;

    // index widths, pointers carry one more bit for wrap
    localparam int READ_Q_PTR_W  = $clog2(READ_Q_DEPTH);
    localparam int WRITE_Q_PTR_W = $clog2(WRITE_Q_DEPTH);

    // advisory threshold on write queue fill
    localparam int SLOW_DOWN_LEVEL = WRITE_Q_DEPTH / 2;

    ////////////////////////////////////////////////////////////
    // basic types

    typedef logic [WORD_W-1:0]       word_t;
    typedef logic [BLOCK_ADDR_W-1:0] block_addr_t;
    // block address plus word offset in lsb
    typedef logic [BLOCK_ADDR_W:0]   word_addr_t;
    // word 0 in the low half
    typedef word_t [1:0]             block_data_t;

    ////////////////////////////////////////////////////////////
    // enums

    typedef enum logic [1:0] {FREE, BUSY, ACCESS, ERROR} ram_state_t;

    typedef enum logic [1:0] {ARBITRATE, ACCESS_0, ACCESS_1, HALT} mem_ctrl_state_t;

    typedef enum logic [1:0] {OP_IMEM0, OP_IMEM1, OP_DMEM_READ, OP_DMEM_WRITE} work_op_t;

    ////////////////////////////////////////////////////////////
    // port structs

    typedef struct packed {
        logic       ren;
        logic       wen;
        word_addr_t addr;
        word_t      store;
    } ram_req_t;

    typedef struct packed {
        ram_state_t state;
        word_t      load;
    } ram_resp_t;

    typedef struct packed {
        logic        ren;
        block_addr_t block_addr;
    } imem_req_t;

    typedef struct packed {
        logic        hit;
        block_data_t load;
    } imem_resp_t;

    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
    } dmem_read_req_t;

    typedef struct packed {
        logic        valid;
        block_data_t data;
    } dmem_read_resp_t;

    typedef struct packed {
        logic        valid;
        block_addr_t block_addr;
        block_data_t data;
    } dmem_write_req_t;

    ////////////////////////////////////////////////////////////
    // queue entries

    // port bit selects which read response fires
    typedef struct packed {
        block_addr_t block_addr;
        logic        port;
    } read_entry_t;

    typedef struct packed {
        block_addr_t block_addr;
        block_data_t data;
    } write_entry_t;

endpackage

// ==== verilog/dmem_read_queue.sv ====
// circular queue of pending data reads, two enqueues and one dequeue per cycle
module dmem_read_queue
    import mem_ctrl_pkg::*;
(
    input  logic           CLK,
    input  logic           nRST,
    input  dmem_read_req_t read_req0,
    input  dmem_read_req_t read_req1,
    input  logic           rd_deq,
    output logic           rd_head_valid,
    output read_entry_t    rd_head
);

    // entry storage, no reset
    read_entry_t q [READ_Q_DEPTH];

    // pointers with wrap bit on top
    logic [READ_Q_PTR_W:0]   head;
    logic [READ_Q_PTR_W:0]   tail;
    logic [READ_Q_PTR_W:0]   count;
    logic [READ_Q_PTR_W-1:0] tail_idx;
    logic [READ_Q_PTR_W-1:0] tail_idx_1;

    // entries headed for tail and tail + 1
    logic [1:0]  enq_cnt;
    read_entry_t first_entry;
    read_entry_t second_entry;

    assign count      = tail - head;
    assign tail_idx   = tail[READ_Q_PTR_W-1:0];
    assign tail_idx_1 = tail_idx + 1'b1;

    assign rd_head_valid = (count != '0);
    assign rd_head       = q[head[READ_Q_PTR_W-1:0]];

    ////////////////////////////////////////////////////////////
    // enqueue

    assign enq_cnt = read_req0.valid + read_req1.valid;

    always_comb begin
        // port 0 first in line when both strobe
        first_entry.block_addr  = read_req0.block_addr;
        first_entry.port        = 1'b0;
        second_entry.block_addr = read_req1.block_addr;
        second_entry.port       = 1'b1;
        // lone port 1 takes the tail slot
        if (!read_req0.valid) begin
            first_entry = second_entry;
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_cnt != 2'd0) begin
            q[tail_idx] <= first_entry;
        end
        if (enq_cnt == 2'd2) begin
            q[tail_idx_1] <= second_entry;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head <= '0;
            tail <= '0;
        end else begin
            tail <= tail + enq_cnt;
            if (rd_deq) begin
                head <= head + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    // fill after this cycle stays within depth
    a_rd_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        (int'(count) + int'(enq_cnt)) <= (READ_Q_DEPTH + int'(rd_deq)));

    // controller pops only a live head
    a_rd_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        rd_deq |-> rd_head_valid);

endmodule

// ==== verilog/dmem_write_queue.sv ====
// circular queue of pending data writes with slow-down and youngest-write forwarding search
module dmem_write_queue
    import mem_ctrl_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    input  dmem_write_req_t write_req0,
    input  dmem_write_req_t write_req1,
    input  logic            wr_deq,
    input  block_addr_t     search_addr,
    output logic            wr_head_valid,
    output write_entry_t    wr_head,
    output logic            wr_empty,
    output logic            slow_down,
    output logic            fwd_hit,
    output block_data_t     fwd_data
);

    // entry storage, no reset
    write_entry_t q [WRITE_Q_DEPTH];

    // pointers with wrap bit on top
    logic [WRITE_Q_PTR_W:0]   head;
    logic [WRITE_Q_PTR_W:0]   tail;
    logic [WRITE_Q_PTR_W:0]   count;
    logic [WRITE_Q_PTR_W-1:0] head_idx;
    logic [WRITE_Q_PTR_W-1:0] tail_idx;
    logic [WRITE_Q_PTR_W-1:0] tail_idx_1;
    // slot under the search loop
    logic [WRITE_Q_PTR_W-1:0] slot;

    logic [1:0]   enq_cnt;
    write_entry_t first_entry;
    write_entry_t second_entry;

    assign count      = tail - head;
    assign head_idx   = head[WRITE_Q_PTR_W-1:0];
    assign tail_idx   = tail[WRITE_Q_PTR_W-1:0];
    assign tail_idx_1 = tail_idx + 1'b1;

    ////////////////////////////////////////////////////////////
    // status

    assign wr_empty      = (head == tail);
    assign wr_head_valid = !wr_empty;
    assign wr_head       = q[head_idx];

    // above half full
    assign slow_down = (int'(count) > SLOW_DOWN_LEVEL);

    ////////////////////////////////////////////////////////////
    // enqueue

    assign enq_cnt = write_req0.valid + write_req1.valid;

    always_comb begin
        first_entry.block_addr  = write_req0.block_addr;
        first_entry.data        = write_req0.data;
        second_entry.block_addr = write_req1.block_addr;
        second_entry.data       = write_req1.data;
        // port 1 alone goes straight to the tail
        if (!write_req0.valid) begin
            first_entry = second_entry;
        end
    end

    always_ff @(posedge CLK) begin
        if (enq_cnt != 2'd0) begin
            q[tail_idx] <= first_entry;
        end
        if (enq_cnt == 2'd2) begin
            q[tail_idx_1] <= second_entry;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            head <= '0;
            tail <= '0;
        end else begin
            tail <= tail + enq_cnt;
            if (wr_deq) begin
                head <= head + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // forwarding search

    // walk oldest to youngest, later match overrides
    // so the survivor is the one farthest from head
    always_comb begin
        fwd_hit  = 1'b0;
        fwd_data = '0;
        slot     = head_idx;
        for (int i = 0; i < WRITE_Q_DEPTH; i++) begin
            slot = head_idx + WRITE_Q_PTR_W'(i);
            // only live entries take part
            if ((i < int'(count)) && (q[slot].block_addr == search_addr)) begin
                fwd_hit  = 1'b1;
                fwd_data = q[slot].data;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    // writers keep to slow_down, so the queue never wraps over head
    a_wr_no_overflow: assert property (@(posedge CLK) disable iff (!nRST)
        (int'(count) + int'(enq_cnt)) <= (WRITE_Q_DEPTH + int'(wr_deq)));

    a_wr_no_underflow: assert property (@(posedge CLK) disable iff (!nRST)
        wr_deq |-> wr_head_valid);

endmodule

// ==== verilog/mem_access_ctrl.sv ====
// arbitration and two-word ram access fsm serving both queues and both fetch ports
module mem_access_ctrl
    import mem_ctrl_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    input  imem_req_t       imem0_req,
    input  imem_req_t       imem1_req,
    input  logic            rd_head_valid,
    input  read_entry_t     rd_head,
    input  logic            wr_head_valid,
    input  write_entry_t    wr_head,
    input  logic            wr_empty,
    input  logic            fwd_hit,
    input  block_data_t     fwd_data,
    input  ram_resp_t       ram_resp,
    input  logic            dcache0_flushed,
    input  logic            dcache1_flushed,
    output logic            rd_deq,
    output logic            wr_deq,
    output block_addr_t     search_addr,
    output ram_req_t        ram_req,
    output imem_resp_t      imem0_resp,
    output imem_resp_t      imem1_resp,
    output dmem_read_resp_t dmem0_resp,
    output dmem_read_resp_t dmem1_resp,
    output logic            flushed
);

    // request under service
    typedef struct packed {
        work_op_t    op;
        logic        port;
        block_addr_t block_addr;
        block_data_t read_data;
        block_data_t write_data;
    } work_t;

    mem_ctrl_state_t state;
    mem_ctrl_state_t next_state;
    work_t           work;
    work_t           next_work;

    // port to serve next when both fetches ask
    logic       lru;
    logic       next_lru;
    // read response valid per data port
    logic [1:0] resp_valid;
    logic [1:0] next_resp_valid;
    logic       ram_done;
    logic       is_write;
    // high in the first cycle after arbitration
    logic       first_access;

    assign ram_done    = (ram_resp.state == ACCESS);
    assign is_write    = (work.op == OP_DMEM_WRITE);
    assign search_addr = work.block_addr;

    // data comes straight from the working copy
    assign dmem0_resp = '{valid: resp_valid[0], data: work.read_data};
    assign dmem1_resp = '{valid: resp_valid[1], data: work.read_data};

    ////////////////////////////////////////////////////////////
    // registers

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state        <= ARBITRATE;
            lru          <= 1'b0;
            resp_valid   <= 2'b00;
            flushed      <= 1'b0;
            first_access <= 1'b0;
        end else begin
            state        <= next_state;
            lru          <= next_lru;
            resp_valid   <= next_resp_valid;
            flushed      <= (state == HALT);
            first_access <= (state == ARBITRATE);
        end
    end

    always_ff @(posedge CLK) begin
        work <= next_work;
    end

    ////////////////////////////////////////////////////////////
    // next state and outputs

    always_comb begin
        next_state      = state;
        next_work       = work;
        next_lru        = lru;
        next_resp_valid = 2'b00;
        rd_deq          = 1'b0;
        wr_deq          = 1'b0;

        // idle bus points at word 0
        ram_req.ren   = 1'b0;
        ram_req.wen   = 1'b0;
        ram_req.addr  = {work.block_addr, 1'b0};
        ram_req.store = work.write_data[0];

        imem0_resp.hit  = 1'b0;
        imem0_resp.load = work.read_data;
        imem1_resp.hit  = 1'b0;
        imem1_resp.load = work.read_data;

        case (state)
            ARBITRATE: begin
                // priority: halt, data read, data write, fetch
                if (dcache0_flushed && dcache1_flushed && wr_empty) begin
                    next_state = HALT;
                end else if (rd_head_valid) begin
                    rd_deq               = 1'b1;
                    next_work.op         = OP_DMEM_READ;
                    next_work.port       = rd_head.port;
                    next_work.block_addr = rd_head.block_addr;
                    next_state           = ACCESS_0;
                end else if (wr_head_valid) begin
                    wr_deq               = 1'b1;
                    next_work.op         = OP_DMEM_WRITE;
                    next_work.port       = 1'b0;
                    next_work.block_addr = wr_head.block_addr;
                    next_work.write_data = wr_head.data;
                    next_state           = ACCESS_0;
                end else if (imem0_req.ren && imem1_req.ren) begin
                    // conflict, lru picks and flips
                    next_work.op         = lru ? OP_IMEM1 : OP_IMEM0;
                    next_work.port       = lru;
                    next_work.block_addr = lru ? imem1_req.block_addr : imem0_req.block_addr;
                    next_lru             = !lru;
                    next_state           = ACCESS_0;
                end else if (imem0_req.ren) begin
                    next_work.op         = OP_IMEM0;
                    next_work.port       = 1'b0;
                    next_work.block_addr = imem0_req.block_addr;
                    next_lru             = 1'b1;
                    next_state           = ACCESS_0;
                end else if (imem1_req.ren) begin
                    next_work.op         = OP_IMEM1;
                    next_work.port       = 1'b1;
                    next_work.block_addr = imem1_req.block_addr;
                    next_lru             = 1'b0;
                    next_state           = ACCESS_0;
                end
            end

            ACCESS_0: begin
                if ((work.op == OP_DMEM_READ) && first_access && fwd_hit) begin
                    // pending write covers the block, ram untouched
                    next_work.read_data        = fwd_data;
                    next_resp_valid[work.port] = 1'b1;
                    next_state                 = ARBITRATE;
                end else begin
                    ram_req.ren = !is_write;
                    ram_req.wen = is_write;
                    if (ram_done) begin
                        next_work.read_data[0] = ram_resp.load;
                        next_state             = ACCESS_1;
                    end
                end
            end

            ACCESS_1: begin
                ram_req.ren   = !is_write;
                ram_req.wen   = is_write;
                ram_req.addr  = {work.block_addr, 1'b1};
                ram_req.store = work.write_data[1];
                if (ram_done) begin
                    next_work.read_data[1] = ram_resp.load;
                    next_state             = ARBITRATE;
                    if (work.op == OP_DMEM_READ) begin
                        next_resp_valid[work.port] = 1'b1;
                    end
                    // fetch hit only if the port still wants this block
                    if ((work.op == OP_IMEM0) && imem0_req.ren &&
                        (imem0_req.block_addr == work.block_addr)) begin
                        imem0_resp.hit  = 1'b1;
                        imem0_resp.load = {ram_resp.load, work.read_data[0]};
                    end
                    if ((work.op == OP_IMEM1) && imem1_req.ren &&
                        (imem1_req.block_addr == work.block_addr)) begin
                        imem1_resp.hit  = 1'b1;
                        imem1_resp.load = {ram_resp.load, work.read_data[0]};
                    end
                end
            end

            // stays put until reset
            HALT: begin
                next_state = HALT;
            end

            default: begin
                next_state = ARBITRATE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // checks

    // a word access in progress keeps its request until the ram reports access
    a_ram_req_held: assert property (@(posedge CLK) disable iff (!nRST)
        ((ram_req.ren || ram_req.wen) && !ram_done) |=> $stable(ram_req));

endmodule

// ==== verilog/dual_mem_controller.sv ====
// top level of the shared memory controller, connects both request queues to the access fsm
module dual_mem_controller
    import mem_ctrl_pkg::*;
(
    input  logic            CLK,
    input  logic            nRST,
    input  imem_req_t       imem0_req,
    input  imem_req_t       imem1_req,
    input  dmem_read_req_t  dmem0_read_req,
    input  dmem_read_req_t  dmem1_read_req,
    input  dmem_write_req_t dmem0_write_req,
    input  dmem_write_req_t dmem1_write_req,
    input  logic            dcache0_flushed,
    input  logic            dcache1_flushed,
    input  ram_resp_t       ram_resp,
    output imem_resp_t      imem0_resp,
    output imem_resp_t      imem1_resp,
    output dmem_read_resp_t dmem0_read_resp,
    output dmem_read_resp_t dmem1_read_resp,
    output logic            slow_down,
    output logic            flushed,
    output ram_req_t        ram_req
);

    ////////////////////////////////////////////////////////////
    // queue to controller wires

    // read side
    logic         rd_head_valid;
    read_entry_t  rd_head;
    logic         rd_deq;
    // write side
    logic         wr_head_valid;
    write_entry_t wr_head;
    logic         wr_empty;
    logic         wr_deq;
    // forwarding
    block_addr_t  search_addr;
    logic         fwd_hit;
    block_data_t  fwd_data;

    dmem_read_queue read_q_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .read_req0     (dmem0_read_req),
        .read_req1     (dmem1_read_req),
        .rd_deq        (rd_deq),
        .rd_head_valid (rd_head_valid),
        .rd_head       (rd_head)
    );

    // slow_down goes out to both write ports as is
    dmem_write_queue write_q_i (
        .CLK           (CLK),
        .nRST          (nRST),
        .write_req0    (dmem0_write_req),
        .write_req1    (dmem1_write_req),
        .wr_deq        (wr_deq),
        .search_addr   (search_addr),
        .wr_head_valid (wr_head_valid),
        .wr_head       (wr_head),
        .wr_empty      (wr_empty),
        .slow_down     (slow_down),
        .fwd_hit       (fwd_hit),
        .fwd_data      (fwd_data)
    );

    mem_access_ctrl access_ctrl_i (
        .CLK             (CLK),
        .nRST            (nRST),
        .imem0_req       (imem0_req),
        .imem1_req       (imem1_req),
        .rd_head_valid   (rd_head_valid),
        .rd_head         (rd_head),
        .wr_head_valid   (wr_head_valid),
        .wr_head         (wr_head),
        .wr_empty        (wr_empty),
        .fwd_hit         (fwd_hit),
        .fwd_data        (fwd_data),
        .ram_resp        (ram_resp),
        .dcache0_flushed (dcache0_flushed),
        .dcache1_flushed (dcache1_flushed),
        .rd_deq          (rd_deq),
        .wr_deq          (wr_deq),
        .search_addr     (search_addr),
        .ram_req         (ram_req),
        .imem0_resp      (imem0_resp),
        .imem1_resp      (imem1_resp),
        .dmem0_resp      (dmem0_read_resp),
        .dmem1_resp      (dmem1_read_resp),
        .flushed         (flushed)
    );

endmodule

// ==== sim/tb_clock_gen.sv ====
// testbench clock and reset source, 10 ns clock with nRST held low for the first 5 cycles
module tb_clock_gen (
    output logic CLK,
    output logic nRST
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 5;

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    // async reset, released on a rising edge
    initial begin
        nRST = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
    end

endmodule

// ==== sim/dual_mem_controller_tb.sv ====
// testbench for the shared memory controller: ram model, stimulus, shadow memory and response checks
module dual_mem_controller_tb
    import mem_ctrl_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RAM_WORDS      = 1 << (BLOCK_ADDR_W + 1);
    localparam int NUM_BLOCKS     = 1 << BLOCK_ADDR_W;

    logic CLK;
    logic nRST;
    imem_req_t       imem0_req, imem1_req;
    imem_resp_t      imem0_resp, imem1_resp;
    dmem_read_req_t  dmem0_read_req, dmem1_read_req;
    dmem_read_resp_t dmem0_read_resp, dmem1_read_resp;
    dmem_write_req_t dmem0_write_req, dmem1_write_req;
    logic            dcache0_flushed, dcache1_flushed, slow_down, flushed;
    ram_req_t        ram_req;
    ram_resp_t       ram_resp;

    // ram array, shadow memory and expected results
    word_t       ram [RAM_WORDS];
    block_data_t shadow [NUM_BLOCKS];
    block_data_t exp_rd0[$], exp_rd1[$];
    // issuing port of each read, oldest first
    logic        rd_order[$];
    imem_resp_t  exp_f0, exp_f1;
    logic [31:0] lcg;
    logic [1:0]  ram_cnt;
    logic        fetch_pend0, fetch_pend1, lru_model, slow_q, flushed_q;
    int          idle_run, cycle_count;
    // writes issued and writes taken out of the queue
    int          wr_issued, wr_started;

    tb_clock_gen clock_gen_i (.CLK(CLK), .nRST(nRST));

    dual_mem_controller dual_mem_controller_i (.*);

    ////////////////////////////////////////////////////////////
    // reference functions

    // odd multiplier keeps every address bit in the word
    function automatic word_t init_word(input word_addr_t a);
        return (word_t'(a) * 32'h9E37_79B1) ^ 32'hC0DE_0000;
    endfunction

    function automatic logic [31:0] next_rand();
        lcg = lcg * 32'd1103515245 + 32'd12345;
        return lcg;
    endfunction

    // small range so blocks collide often
    function automatic block_addr_t rand_block();
        logic [31:0] r;
        r = next_rand();
        return block_addr_t'(r[13:8]);
    endfunction

    ////////////////////////////////////////////////////////////
    // ram model, two busy cycles then access

    always_comb begin
        ram_resp.load  = ram[ram_req.addr];
        ram_resp.state = FREE;
        if (ram_req.ren || ram_req.wen) begin
            ram_resp.state = (ram_cnt == 2'd2) ? ACCESS : BUSY;
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            ram_cnt <= 2'd0;
        end else if (ram_req.ren || ram_req.wen) begin
            ram_cnt <= (ram_cnt == 2'd2) ? 2'd0 : ram_cnt + 2'd1;
            if (ram_req.wen && (ram_cnt == 2'd2)) begin
                ram[ram_req.addr] <= ram_req.store;
            end
        end else begin
            ram_cnt <= 2'd0;
        end
    end

    ////////////////////////////////////////////////////////////
    // failure reporting and compare tasks

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_block(input block_data_t got, input block_data_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_fetch(input imem_resp_t got, input imem_resp_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("error at %0d ns: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    // contested fetch goes to lru port, then lru points away from the winner
    task automatic note_fetch(input logic port, input logic contested);
        if (contested && (port != lru_model)) begin
            abort_run($sformatf("error at %0d ns: fetch port %0d served against lru", $time, port));
        end
        lru_model = !port;
    endtask

    ////////////////////////////////////////////////////////////
    // compare process, samples on the falling edge

    always @(negedge CLK) begin
        slow_q    = slow_down;
        flushed_q = flushed;
        idle_run  = (ram_req.ren || ram_req.wen) ? 0 : idle_run + 1;
        if (nRST) begin
            // a write leaves the queue when its first word access starts
            if (ram_req.wen && !ram_req.addr[0] && (ram_cnt == 2'd0)) begin
                wr_started = wr_started + 1;
            end
            check_bit(slow_down, (wr_issued - wr_started) > SLOW_DOWN_LEVEL, "slow_down");
            // strobes seen now enter the queue on the next edge
            wr_issued = wr_issued + int'(dmem0_write_req.valid) + int'(dmem1_write_req.valid);
            if (dmem0_read_resp.valid) begin
                if (exp_rd0.size() == 0) abort_run("read response on port 0 with no read pending");
                if (rd_order.pop_front() != 1'b0) begin
                    abort_run("read on port 0 answered ahead of an older read on port 1");
                end
                check_block(dmem0_read_resp.data, exp_rd0.pop_front(), "read port 0");
            end
            if (dmem1_read_resp.valid) begin
                if (exp_rd1.size() == 0) abort_run("read response on port 1 with no read pending");
                if (rd_order.pop_front() != 1'b1) begin
                    abort_run("read on port 1 answered ahead of an older read on port 0");
                end
                check_block(dmem1_read_resp.data, exp_rd1.pop_front(), "read port 1");
            end
            if (imem0_resp.hit) begin
                if (!imem0_req.ren || !fetch_pend0) abort_run("fetch hit on port 0 without a request");
                check_fetch(imem0_resp, exp_f0, "fetch port 0");
                note_fetch(1'b0, fetch_pend1);
                fetch_pend0 = 1'b0;
            end
            if (imem1_resp.hit) begin
                if (!imem1_req.ren || !fetch_pend1) abort_run("fetch hit on port 1 without a request");
                check_fetch(imem1_resp, exp_f1, "fetch port 1");
                note_fetch(1'b1, fetch_pend0);
                fetch_pend1 = 1'b0;
            end
        end
    end

    // run limit
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the controller stopped making progress");
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers

    // one cycle of data requests, shadow takes port 1 after port 0
    task automatic step(input dmem_read_req_t r0, input dmem_read_req_t r1,
                        input dmem_write_req_t w0, input dmem_write_req_t w1);
        @(posedge CLK);
        dmem0_read_req  <= r0;
        dmem1_read_req  <= r1;
        dmem0_write_req <= w0;
        dmem1_write_req <= w1;
        if (w0.valid) shadow[w0.block_addr] = w0.data;
        if (w1.valid) shadow[w1.block_addr] = w1.data;
        if (r0.valid) begin
            exp_rd0.push_back(shadow[r0.block_addr]);
            rd_order.push_back(1'b0);
        end
        if (r1.valid) begin
            exp_rd1.push_back(shadow[r1.block_addr]);
            rd_order.push_back(1'b1);
        end
    endtask

    task automatic idle();
        step('0, '0, '0, '0);
    endtask

    // at most two reads in flight per port
    task automatic read_req(input logic v0, input block_addr_t a0,
                            input logic v1, input block_addr_t a1);
        while (exp_rd0.size() >= 2 || exp_rd1.size() >= 2) idle();
        step('{valid: v0, block_addr: a0}, '{valid: v1, block_addr: a1}, '0, '0);
    endtask

    task automatic write_req(input logic v0, input block_addr_t a0, input block_data_t d0,
                             input logic v1, input block_addr_t a1, input block_data_t d1);
        while (slow_q) idle();
        step('0, '0, '{valid: v0, block_addr: a0, data: d0},
             '{valid: v1, block_addr: a1, data: d1});
        idle();
    endtask

    // ram quiet for a while means both queues are drained
    task automatic wait_quiet();
        repeat (3) idle();
        while (idle_run < 4 || exp_rd0.size() != 0 || exp_rd1.size() != 0) idle();
    endtask

    ////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        block_addr_t b;
        block_data_t d0, d1;
        lcg = 32'h4481;
        {imem0_req, imem1_req, dmem0_read_req, dmem1_read_req} = '0;
        {dmem0_write_req, dmem1_write_req, dcache0_flushed, dcache1_flushed} = '0;
        {fetch_pend0, fetch_pend1, lru_model, slow_q, flushed_q} = '0;
        idle_run    = 0;
        cycle_count = 0;
        wr_issued   = 0;
        wr_started  = 0;
        for (int i = 0; i < RAM_WORDS; i++) ram[i] = init_word(word_addr_t'(i));
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            shadow[i] = {init_word(word_addr_t'(2 * i + 1)), init_word(word_addr_t'(2 * i))};
        end
        @(posedge nRST);
        idle();

        // single reads per port, then paired reads
        for (int i = 0; i < 8; i++) read_req(i[0] == 1'b0, rand_block(), i[0], rand_block());
        for (int i = 0; i < 8; i++) read_req(1'b1, rand_block(), 1'b1, rand_block());
        wait_quiet();

        // same block written by both ports behind a busy read, read at once, then from ram
        b  = 13'h155;
        d0 = {next_rand(), next_rand()};
        d1 = {next_rand(), next_rand()};
        step('{valid: 1'b1, block_addr: b + 13'd1}, '0,
             '{valid: 1'b1, block_addr: b, data: d0},
             '{valid: 1'b1, block_addr: b, data: d1});
        read_req(1'b1, b, 1'b0, '0);
        wait_quiet();
        read_req(1'b0, '0, 1'b1, b);
        wait_quiet();

        // both fetch ports hold ren until their hit
        for (int i = 0; i < 6; i++) begin
            @(posedge CLK);
            imem0_req <= '{ren: 1'b1, block_addr: rand_block()};
            imem1_req <= '{ren: 1'b1, block_addr: rand_block() + 13'd100};
            #1;
            exp_f0      = '{hit: 1'b1, load: shadow[imem0_req.block_addr]};
            exp_f1      = '{hit: 1'b1, load: shadow[imem1_req.block_addr]};
            fetch_pend0 = 1'b1;
            fetch_pend1 = 1'b1;
            while (fetch_pend0 || fetch_pend1) begin
                @(posedge CLK);
                if (!fetch_pend0) imem0_req.ren <= 1'b0;
                if (!fetch_pend1) imem1_req.ren <= 1'b0;
            end
        end

        // write burst paced by slow_down, then random read-back
        for (int i = 0; i < 60; i++) begin
            write_req(i % 3 != 1, rand_block(), {next_rand(), next_rand()},
                      i % 3 != 2, rand_block(), {next_rand(), next_rand()});
        end
        wait_quiet();
        for (int i = 0; i < 40; i++) read_req(1'b1, rand_block(), i[0], rand_block());
        wait_quiet();

        // halt once both caches report flushed
        @(posedge CLK);
        dcache0_flushed <= 1'b1;
        dcache1_flushed <= 1'b1;
        while (!flushed_q) idle();
        repeat (10) begin
            idle();
            if (!flushed_q) abort_run("flushed dropped after the controller halted");
        end
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            check_block({ram[2 * i + 1], ram[2 * i]}, shadow[i], $sformatf("ram block %0d", i));
        end

        if (exp_rd0.size() == 0 && exp_rd1.size() == 0 && flushed_q) begin
            $display("TEST PASS");
            $finish;
        end else begin
            abort_run("reads still pending at the end of the run");
        end
    end

endmodule

// ==== project.f ====
verilog/mem_ctrl_pkg.sv
verilog/dmem_read_queue.sv
verilog/dmem_write_queue.sv
verilog/mem_access_ctrl.sv
verilog/dual_mem_controller.sv
sim/tb_clock_gen.sv
sim/dual_mem_controller_tb.sv

// ==== Makefile ====
TOP := dual_mem_controller_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf obj_dir
